//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_intc -Mdir obj_dir
	./obj_dir/Vtb_intc | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_intc_tasks.svh
`ifndef TB_INTC_TASKS_SVH
`define TB_INTC_TASKS_SVH

// Vector word on bus_out.
task automatic check_vector(input logic [`INTC_BUS_W-1:0] got,
                            input logic [`INTC_BUS_W-1:0] exp, input string what);
    if (got !== exp) begin
        mismatch_cnt++;
        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

// Single control bit such as bus_oe or irq_out.
task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        mismatch_cnt++;
        $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

// Random nonzero request set without the skipped source.
// A negative skip keeps all bits.
function automatic logic [`INTC_SOURCES-1:0] pick_request_set(input int skip);
    int unsigned r;
    logic [`INTC_SOURCES-1:0] v;
    r = $urandom();
    v = r[`INTC_SOURCES-1:0];
    if (skip >= 0) begin
        v[skip] = 1'b0;                                 // Served source stays quiet.
    end
    if (v == '0) begin
        v[(skip + 1) % `INTC_SOURCES] = 1'b1;           // Never empty.
    end
    return v;
endfunction

// Next source by the mode's rule on the current requests.
function automatic logic [`INTC_ID_W-1:0] expected_id();
    logic found;
    logic [`INTC_ID_W-1:0] idx;
    found       = 1'b0;
    expected_id = last_idx;
    for (int i = 0; i < `INTC_SOURCES; i++) begin
        if (model_mode == MODE_PRIO) begin
            idx = model_tbl[i];                         // Table order from the top entry.
        end
        else begin
            idx = last_idx + 3'(i);                     // Cyclic from the last served.
        end
        if (!found && irq[idx]) begin
            found       = 1'b1;
            expected_id = idx;
        end
    end
endfunction

// One word on the bus for a single cycle before it returns to zero.
task automatic send_word(input logic [`INTC_BUS_W-1:0] word);
    @(posedge clk_in);
    bus_in <= word;
    @(posedge clk_in);
    bus_in <= '0;
endtask

// One cycle ack pulse carrying a bus word and the next request set.
task automatic pulse_ack(input logic [`INTC_BUS_W-1:0] word,
                         input logic [`INTC_SOURCES-1:0] next_irq);
    @(posedge clk_in);
    ack_n  <= 1'b0;
    bus_in <= word;
    irq    <= next_irq;
    @(posedge clk_in);
    ack_n  <= 1'b1;
    bus_in <= '0;                                   // Keeps command mode from misreading it.
endtask

task automatic wait_for_irq(output logic found);
    found = 1'b0;
    for (int i = 0; i < WAIT_LIMIT && !found; i++) begin
        @(negedge clk_in);
        found = irq_out;
    end
endtask

// irq_out must stay low for the whole span.
task automatic expect_quiet(input int cycles, input string what);
    for (int i = 0; i < cycles; i++) begin
        @(negedge clk_in);
        if (irq_out) begin
            other_cnt++;
            $display("ERROR: irq_out rose during %s at %0t", what, $time);
            return;
        end
    end
endtask

task automatic configure_poll();
    int unsigned r;
    logic [`INTC_BUS_W-1:0] word;
    r    = $urandom();
    word = r[`INTC_BUS_W-1:0];
    word[1:0] = `INTC_CMD_POLL;
    send_word(word);
    model_mode = MODE_POLL;
    last_idx   = '0;                                // Scan starts at source 0.
endtask

// Random permutation sent as two entries per word.
task automatic configure_prio();
    int j;
    logic [`INTC_ID_W-1:0] tmp;
    for (int i = 0; i < `INTC_SOURCES; i++) begin
        model_tbl[i] = 3'(i);
    end
    for (int i = `INTC_SOURCES - 1; i > 0; i--) begin
        j            = int'($urandom_range(i, 0));
        tmp          = model_tbl[i];
        model_tbl[i] = model_tbl[j];
        model_tbl[j] = tmp;
    end
    for (int w = 0; w < 4; w++) begin
        send_word({model_tbl[2 * w], model_tbl[2 * w + 1], `INTC_CMD_PRIO});
    end
    model_mode = MODE_PRIO;
    last_idx   = '0;
endtask

// Full handshake for one interrupt; a bad done word forces an abort.
task automatic serve_one(input logic bad_done);
    logic found;
    int unsigned r;
    logic [`INTC_ID_W-1:0] exp_id;
    logic [`INTC_CODE_W-1:0] vec_code;
    logic [`INTC_CODE_W-1:0] done_code;
    logic [`INTC_BUS_W-1:0] done_word;
    logic [`INTC_SOURCES-1:0] left;
    wait_for_irq(found);
    if (!found) begin
        other_cnt++;
        $display("ERROR: irq_out did not rise within %0d cycles at %0t", WAIT_LIMIT, $time);
        return;
    end
    check_flag(bus_oe, 1'b0, "bus_oe while irq_out is high");
    exp_id    = expected_id();
    vec_code  = (model_mode == MODE_PRIO) ? `INTC_VEC_PRIO : `INTC_VEC_POLL;
    done_code = (model_mode == MODE_PRIO) ? `INTC_DONE_PRIO : `INTC_DONE_POLL;

    repeat ($urandom_range(3, 0)) @(posedge clk_in);   // Processor latency.
    pulse_ack('0, irq);
    @(negedge clk_in);
    check_flag(irq_out, 1'b0, "irq_out after first ack");
    check_flag(bus_oe, 1'b1, "bus_oe after first ack");
    check_vector(bus_out, {vec_code, exp_id}, "vector word");
    for (int d = $urandom_range(3, 0); d > 0; d--) begin
        @(negedge clk_in);
        check_flag(bus_oe, 1'b1, "bus_oe before second ack");
    end

    // The served request drops with the bus release ack.
    left         = irq;
    left[exp_id] = 1'b0;
    if (left == '0) begin
        left = pick_request_set(int'(exp_id));
    end
    pulse_ack('0, left);
    @(negedge clk_in);
    check_flag(bus_oe, 1'b0, "bus_oe after second ack");

    done_word = {done_code, exp_id};
    if (bad_done) begin
        r = $urandom();
        if (r[0]) begin
            done_word[`INTC_ID_W-1:0] = exp_id ^ 3'(r[3:1] | 3'b001);  // Wrong ID.
        end
        else begin
            done_word[`INTC_BUS_W-1:`INTC_ID_W] = done_code ^ 5'(r[5:1] | 5'b00001);
        end
    end
    repeat ($urandom_range(3, 0)) @(posedge clk_in);
    pulse_ack(done_word, irq);
    last_idx = exp_id;
    if (bad_done) begin
        model_mode = MODE_NONE;                         // DUT drops back to command mode.
        last_idx   = '0;
    end
endtask

`endif

//--- bench/tb_intc.sv
`default_nettype none

`include "intc_params.svh"

module tb_intc;

    timeunit 1ns;
    timeprecision 100ps;

    import intc_pkg::*;

    localparam int WAIT_LIMIT = 200;        // Cycles any wait may take.
    localparam int QUIET_SPAN = 40;         // Cycles irq_out must stay low.

    logic                       clk_in;
    logic                       rst_in;
    logic [`INTC_SOURCES-1:0]   irq;
    logic                       ack_n;
    logic [`INTC_BUS_W-1:0]     bus_in;
    logic                       irq_out;
    logic [`INTC_BUS_W-1:0]     bus_out;
    logic                       bus_oe;

    // Reference model state.
    mode_e                      model_mode;                     // Mode the DUT should be in.
    logic [`INTC_ID_W-1:0]      model_tbl [`INTC_SOURCES];      // Entry 0 is the top priority.
    logic [`INTC_ID_W-1:0]      last_idx;                       // Last served source.
    int                         mismatch_cnt;
    int                         other_cnt;

    intc_top i_dut (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .irq     (irq),
        .ack_n   (ack_n),
        .bus_in  (bus_in),
        .irq_out (irq_out),
        .bus_out (bus_out),
        .bus_oe  (bus_oe)
    );

    // 4 ns clock.
    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    `include "tb_intc_tasks.svh"

    initial begin : run
        int unsigned r;
        logic [`INTC_BUS_W-1:0] word;

        void'($urandom(32'hd5badf42));          // Seeds the generator for the whole run.
        mismatch_cnt = 0;
        other_cnt    = 0;
        rst_in       = 1'b1;
        irq          = '0;
        ack_n        = 1'b1;
        bus_in       = '0;
        model_mode   = MODE_NONE;
        last_idx     = '0;
        for (int i = 0; i < `INTC_SOURCES; i++) begin
            model_tbl[i] = '0;
        end

        repeat (5) @(posedge clk_in);           // Reset held for five cycles.
        rst_in <= 1'b0;
        @(posedge clk_in);
        irq <= pick_request_set(-1);            // Requests pending before any mode.

        // Words with selector 00 or 11 carry no command.
        for (int n = 0; n < 6; n++) begin
            r    = $urandom();
            word = r[`INTC_BUS_W-1:0];
            word[1:0] = r[8] ? 2'b11 : 2'b00;
            send_word(word);
        end
        expect_quiet(QUIET_SPAN, "ignored command words");

        // Polling run.
        configure_poll();
        for (int n = 0; n < 24; n++) begin
            serve_one(1'b0);
        end

        // Bad done word followed by the priority run.
        serve_one(1'b1);
        expect_quiet(QUIET_SPAN, "command mode after abort");
        configure_prio();
        for (int n = 0; n < 24; n++) begin
            serve_one(1'b0);
        end

        // Abort out of priority mode and back to polling.
        serve_one(1'b1);
        expect_quiet(QUIET_SPAN, "command mode after second abort");
        configure_poll();
        for (int n = 0; n < 12; n++) begin
            serve_one(1'b0);
        end

        repeat (4) @(posedge clk_in);
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
+incdir+bench
hdl/intc_pkg.sv
hdl/intc_cmd.sv
hdl/intc_select.sv
hdl/intc_service.sv
hdl/intc_top.sv
bench/tb_intc.sv

//--- hdl/intc_cmd.sv
`default_nettype none

`include "intc_params.svh"

module intc_cmd (
    input  wire                     clk_in,
    input  wire                     rst_in,
    input  wire [`INTC_BUS_W-1:0]   bus_in,     // Command words from the processor.
    input  wire                     abort,      // Bad done word seen by service.
    output intc_pkg::intc_cfg_t     cfg
);

    import intc_pkg::*;

    // Positions of the two table fields inside a priority word.
    localparam int HI_LSB = `INTC_BUS_W - `INTC_ID_W;   // Bits 7:5.
    localparam int LO_LSB = HI_LSB - `INTC_ID_W;        // Bits 4:2.

    logic [1:0] word_cnt;   // Priority words taken so far.

    // The bus is read every cycle while unconfigured.
    // Two table entries arrive per priority word with the higher one first.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cfg      <= '0;             // Mode falls back to MODE_NONE.
            word_cnt <= 2'd0;
        end
        else if (abort) begin
            // Back to command mode with an empty table and count.
            cfg.mode     <= MODE_NONE;
            cfg.prio_tbl <= '0;
            word_cnt     <= 2'd0;
        end
        else if (cfg.mode == MODE_NONE) begin
            case (bus_in[1:0])
                `INTC_CMD_POLL: begin
                    cfg.mode <= MODE_POLL;                              // Polling starts now.
                end
                `INTC_CMD_PRIO: begin
                    cfg.prio_tbl[{word_cnt, 1'b0}] <= bus_in[HI_LSB +: `INTC_ID_W];
                    cfg.prio_tbl[{word_cnt, 1'b1}] <= bus_in[LO_LSB +: `INTC_ID_W];
                    word_cnt <= word_cnt + 2'd1;                        // Wraps to 0 after the last.
                    if (word_cnt == 2'd3) begin
                        cfg.mode <= MODE_PRIO;                          // Table complete.
                    end
                end
                default: begin
                    // Words 00 and 11 carry no command.
                end
            endcase
        end
    end

    // Mode register only ever holds a legal encoding.
    a_mode_legal: assert property (
        @(posedge clk_in) disable iff (rst_in)
        cfg.mode inside {MODE_NONE, MODE_POLL, MODE_PRIO}
    ) else $error("intc_cmd: illegal mode %b", cfg.mode);

endmodule

`default_nettype wire

//--- hdl/intc_params.svh
`ifndef INTC_PARAMS_SVH
`define INTC_PARAMS_SVH

// Request lines and the ID that names one of them.
`define INTC_SOURCES    8
`define INTC_ID_W       3           // Enough bits for eight sources.

// A bus word holds a condition code above a source ID.
`define INTC_BUS_W      8
`define INTC_CODE_W     5           // Upper bits of a bus word.

// Codes the controller sends along with the vector.
`define INTC_VEC_POLL   5'b01011    // Polling mode.
`define INTC_VEC_PRIO   5'b10011    // Priority mode.

// Codes the processor returns when the handler is finished.
`define INTC_DONE_POLL  5'b10100    // Polling mode.
`define INTC_DONE_PRIO  5'b01100    // Priority mode.

// Command word selectors in the two low bits.
`define INTC_CMD_POLL   2'b01
`define INTC_CMD_PRIO   2'b10

`endif

//--- hdl/intc_pkg.sv
`default_nettype none

`include "intc_params.svh"

package intc_pkg;

    // Operating mode of the controller.
    // The encoding follows the command word selector.
    typedef enum logic [1:0] {
        MODE_NONE = 2'b00,  // Unconfigured, waiting for commands.
        MODE_POLL = 2'b01,  // Fixed order polling.
        MODE_PRIO = 2'b10   // Programmed priority table.
    } mode_e;

    // Configuration held by the command stage.
    // Entry 0 of the table is the highest priority.
    typedef struct packed {
        mode_e                                      mode;
        logic [`INTC_SOURCES-1:0][`INTC_ID_W-1:0]   prio_tbl;
    } intc_cfg_t;

    // One pending grant handed from select to service.
    typedef struct packed {
        logic                   valid;  // Slot holds a source.
        logic [`INTC_ID_W-1:0]  id;     // Granted source.
        mode_e                  mode;   // Mode in force when granted.
    } intc_grant_t;

endpackage

`default_nettype wire

//--- hdl/intc_select.sv
`default_nettype none

`include "intc_params.svh"

module intc_select (
    input  wire                         clk_in,
    input  wire                         rst_in,
    input  wire [`INTC_SOURCES-1:0]     irq,        // Level requests.
    input  wire intc_pkg::intc_cfg_t    cfg,        // Mode and table from intc_cmd.
    input  wire                         accept,     // Service took the grant.
    output intc_pkg::intc_grant_t       grant
);

    import intc_pkg::*;

    intc_grant_t            slot;       // One entry grant buffer.
    logic [`INTC_ID_W-1:0]  poll_idx;   // Source checked this cycle in polling.
    logic                   prio_hit;   // Some table entry is requesting.
    logic [`INTC_ID_W-1:0]  prio_id;    // Best requesting table entry.
    logic                   configured;

    assign configured = (cfg.mode != MODE_NONE);

    // Table scan from the lowest priority up so the top entry wins.
    always_comb begin
        prio_hit = 1'b0;
        prio_id  = '0;
        for (int i = `INTC_SOURCES - 1; i >= 0; i--) begin
            if (irq[cfg.prio_tbl[i]]) begin
                prio_hit = 1'b1;
                prio_id  = cfg.prio_tbl[i];
            end
        end
    end

    // Slot handling.
    // Fill only when empty; empty on accept or on a withdrawn request.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            slot     <= '0;
            poll_idx <= '0;
        end
        else if (!configured) begin
            slot.valid <= 1'b0;         // Nothing is granted in command mode.
            poll_idx   <= '0;           // Polling restarts from source 0.
        end
        else if (slot.valid) begin
            if (accept || !irq[slot.id]) begin
                slot.valid <= 1'b0;     // Taken or cancelled.
            end
        end
        else if (cfg.mode == MODE_POLL) begin
            if (irq[poll_idx]) begin
                slot.valid <= 1'b1;
                slot.id    <= poll_idx; // Index stays put after a grant.
                slot.mode  <= MODE_POLL;
            end
            else begin
                poll_idx <= poll_idx + 1'b1;   // One source per cycle.
            end
        end
        else if (prio_hit) begin
            slot.valid <= 1'b1;
            slot.id    <= prio_id;
            slot.mode  <= MODE_PRIO;
        end
    end

    // A stale slot is hidden in the cycle right after an abort.
    always_comb begin
        grant       = slot;
        grant.valid = slot.valid && configured;
    end

    // A fresh grant names a source that is still requesting.
    a_grant_requesting: assert property (
        @(posedge clk_in) disable iff (rst_in)
        $rose(grant.valid) |-> irq[grant.id]
    ) else $error("intc_select: granted source %0d not requesting", grant.id);

endmodule

`default_nettype wire

//--- hdl/intc_service.sv
`default_nettype none

`include "intc_params.svh"

module intc_service (
    input  wire                         clk_in,
    input  wire                         rst_in,
    input  wire intc_pkg::intc_grant_t  grant,      // Pending grant from select.
    input  wire                         ack_n,      // Processor acknowledge, low active.
    input  wire [`INTC_BUS_W-1:0]       bus_in,     // Done word from the processor.
    output logic                        accept,     // Empties the select slot.
    output logic                        abort,      // Sends intc_cmd back to command mode.
    output logic                        irq_out,
    output logic                        bus_oe,
    output logic [`INTC_BUS_W-1:0]      bus_out
);

    import intc_pkg::*;

    // Handshake states.
    typedef enum logic [1:0] {
        S_IDLE,         // Waiting for a grant.
        S_RAISED,       // Interrupt up until the first ack.
        S_VECTOR,       // Vector on the bus until the second ack.
        S_WAIT_DONE     // Bus released until the done word arrives.
    } state_e;

    state_e                     state;
    logic [`INTC_ID_W-1:0]      cur_id;     // Source in service.
    mode_e                      cur_mode;   // Mode it was granted in.
    logic [`INTC_CODE_W-1:0]    vec_code;
    logic [`INTC_CODE_W-1:0]    done_code;
    logic                       ack;        // Acknowledge seen this cycle.
    logic                       done_ok;    // Done word matches code and ID.

    assign ack = !ack_n;

    // Condition codes for the mode of the source in service.
    assign vec_code  = (cur_mode == MODE_PRIO) ? `INTC_VEC_PRIO  : `INTC_VEC_POLL;
    assign done_code = (cur_mode == MODE_PRIO) ? `INTC_DONE_PRIO : `INTC_DONE_POLL;

    // Any mismatch in code or ID counts as a bad done word.
    assign done_ok = (bus_in == {done_code, cur_id});

    assign accept = (state == S_IDLE) && grant.valid;
    assign abort  = (state == S_WAIT_DONE) && ack && !done_ok;

    // Control path.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state   <= S_IDLE;
            irq_out <= 1'b0;
            bus_oe  <= 1'b0;
        end
        else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        irq_out <= 1'b1;            // Rises the cycle after accept.
                        state   <= S_RAISED;
                    end
                end
                S_RAISED: begin
                    if (ack) begin
                        irq_out <= 1'b0;            // Interrupt acknowledged.
                        bus_oe  <= 1'b1;            // Vector goes out at the same edge.
                        state   <= S_VECTOR;
                    end
                end
                S_VECTOR: begin
                    if (ack) begin
                        bus_oe <= 1'b0;             // Processor has the vector.
                        state  <= S_WAIT_DONE;
                    end
                end
                S_WAIT_DONE: begin
                    if (ack) begin
                        state <= S_IDLE;            // Abort is pulsed on a bad word.
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Data path for the source in service and its vector word.
    always_ff @(posedge clk_in) begin
        if (accept) begin
            cur_id   <= grant.id;
            cur_mode <= grant.mode;
        end
        if (state == S_RAISED && ack) begin
            bus_out <= {vec_code, cur_id};
        end
    end

    // The interrupt line and the bus drive never overlap.
    a_irq_oe_excl: assert property (
        @(posedge clk_in) disable iff (rst_in)
        !(irq_out && bus_oe)
    ) else $error("intc_service: irq_out and bus_oe high together");

endmodule

`default_nettype wire

//--- hdl/intc_top.sv
`default_nettype none

`include "intc_params.svh"

module intc_top (
    input  wire                         clk_in,
    input  wire                         rst_in,
    input  wire [`INTC_SOURCES-1:0]     irq,        // Level requests from the sources.
    input  wire                         ack_n,      // Processor acknowledge.
    input  wire [`INTC_BUS_W-1:0]       bus_in,     // Word driven by the processor.
    output logic                        irq_out,    // Interrupt to the processor.
    output logic [`INTC_BUS_W-1:0]      bus_out,    // Vector word.
    output logic                        bus_oe      // bus_out is valid.
);

    import intc_pkg::*;

    intc_cfg_t      cfg;        // Mode and priority table.
    intc_grant_t    grant;      // Next source to serve.
    logic           accept;     // Grant taken by service.
    logic           abort;      // Bad done word.

    // Command stage.
    intc_cmd u_cmd (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .bus_in  (bus_in),
        .abort   (abort),
        .cfg     (cfg)
    );

    // Select stage.
    intc_select u_select (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .irq     (irq),
        .cfg     (cfg),
        .accept  (accept),
        .grant   (grant)
    );

    // Service stage, owns the processor side.
    intc_service u_service (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .grant   (grant),
        .ack_n   (ack_n),
        .bus_in  (bus_in),
        .accept  (accept),
        .abort   (abort),
        .irq_out (irq_out),
        .bus_oe  (bus_oe),
        .bus_out (bus_out)
    );

endmodule

`default_nettype wire
